// File: hw/mfrsd_pkg.sv
package mfrsd_pkg;

   ////////////////////////////////////////
   // bus structures
   ////////////////////////////////////////

   // one cpu memory cycle as the cartridge sees it.
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        mreq;
      logic        wr;
      logic        rd;
   } cpu_bus_t;

   // request towards the external flash and ram.
   typedef struct packed {
      logic [22:0] flash_addr;
      logic [26:0] mem_addr;
      logic        flash_rq;
      logic        unmapped;
   } mem_req_t;

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////

   localparam logic [15:0] SUBSLOT_REG_ADDR = 16'hFFFF;

   localparam logic [15:0] CFG_REG_ADDR     = 16'h7FFC;
   localparam logic [15:0] OFFSET_LO_ADDR   = 16'h7FFD;
   localparam logic [15:0] OFFSET_HI_ADDR   = 16'h7FFE;
   localparam logic [15:0] MAPPER_REG_ADDR  = 16'h7FFF;

   // flash regions.
   localparam logic [22:0] ROM_FLASH_BASE   = 23'h010000;
   localparam logic [22:0] SD_FLASH_BASE    = 23'h700000;

   // sub-slot numbers of the two mappers.
   localparam logic [1:0]  ROM_SUBSLOT      = 2'd1;
   localparam logic [1:0]  SD_SUBSLOT       = 2'd3;

   ////////////////////////////////////////
   // spi timing
   ////////////////////////////////////////

   // clocks per sclk half period.
   localparam logic [3:0]  SPI_HALF_CLKS    = 4'd2;
   localparam logic [3:0]  SPI_BITS         = 4'd8;

endpackage

// File: hw/slot_expander.sv
module slot_expander import mfrsd_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       slot_cs,
   input  cpu_bus_t   cpu,
   input  mem_req_t   rom_req,
   input  mem_req_t   sd_req,
   input  logic [7:0] rom_dout,
   input  logic [7:0] sd_dout,
   output logic       rom_cs,
   output logic       sd_cs,
   output mem_req_t   mem,
   output logic [7:0] rd_data,
   output logic       rd_en
);

   logic [7:0] subslot_reg;
   logic [1:0] page_sub;
   logic       ssr_hit;

   assign ssr_hit = slot_cs & (cpu.addr == SUBSLOT_REG_ADDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         subslot_reg <= 8'h00;
      end else if (ssr_hit & cpu.mreq & cpu.wr) begin
         subslot_reg <= cpu.wdata;
      end
   end

   // two bits per 16 kB page, page 0 in the low bits.
   assign page_sub = subslot_reg[2 * cpu.addr[15:14] +: 2];

   assign rom_cs = slot_cs & ~ssr_hit & (page_sub == ROM_SUBSLOT);
   assign sd_cs  = slot_cs & ~ssr_hit & (page_sub == SD_SUBSLOT);

   always_comb begin
      if (rom_cs) begin
         mem = rom_req;
      end else if (sd_cs) begin
         mem = sd_req;
      end else begin
         // sub-slots 0 and 2 and the register itself.
         mem          = '0;
         mem.unmapped = slot_cs;
      end
   end

   always_comb begin
      if (ssr_hit) begin
         rd_data = ~subslot_reg;
      end else if (sd_cs) begin
         rd_data = sd_dout;
      end else if (rom_cs) begin
         rd_data = rom_dout;
      end else begin
         rd_data = 8'hFF;
      end
   end

   assign rd_en = slot_cs & cpu.mreq & cpu.rd & mem.unmapped;

endmodule

// File: hw/rom_mapper.sv
module rom_mapper import mfrsd_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        cs,
   input  cpu_bus_t    cpu,
   input  logic [26:0] base_ram,
   output mem_req_t    req,
   output logic [7:0]  cfg_reg,
   output logic        scc_req,
   output logic        scc_plus
);

   logic [7:0]      mapper_reg;
   logic [7:0]      scc_mode;
   logic [9:0]      offset_reg;
   logic [3:0][7:0] bank;
   logic [3:0][7:0] scc_bank;
   logic            wr_cycle;
   logic [2:0]      page8k;
   logic [2:0]      page;
   logic            page16;
   logic            addr_valid;
   logic [15:0]     bank_value;
   logic [22:0]     flash_off;
   logic            en_scc;
   logic            en_scc_plus;
   logic            ram_seg2;
   logic            ram_seg3;

   assign wr_cycle = cs & cpu.mreq & cpu.wr;
   assign page8k   = cpu.addr[15:13] - 3'd2;

   ////////////////////////////////////////
   // control registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_reg    <= 8'h03;
         mapper_reg <= 8'h00;
         offset_reg <= 10'd0;
         scc_mode   <= 8'h00;
      end else if (wr_cycle) begin
         case (cpu.addr)
            CFG_REG_ADDR: begin
               if (!cfg_reg[7])
                  cfg_reg <= cpu.wdata;
            end
            OFFSET_LO_ADDR: begin
               if (!mapper_reg[1])
                  offset_reg[7:0] <= cpu.wdata;
            end
            OFFSET_HI_ADDR: begin
               if (!mapper_reg[1])
                  offset_reg[9:8] <= cpu.wdata[1:0];
            end
            MAPPER_REG_ADDR: begin
               if (!mapper_reg[2])
                  mapper_reg <= cpu.wdata;
            end
            16'hBFFE, 16'hBFFF: begin
               // scc mode register, konami-scc only.
               if (mapper_reg[7:5] == 3'b000)
                  scc_mode <= cpu.wdata;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // bank registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         bank     <= {8'd3, 8'd2, 8'd1, 8'd0};
         scc_bank <= {8'd3, 8'd2, 8'd1, 8'd0};
      end else if (wr_cycle & ~mapper_reg[1] & (page8k < 3'd4)) begin
         case (mapper_reg[7:5])
            3'b000: begin
               // konami-scc, bank select at 5000, 7000, 9000, b000.
               if (cpu.addr[12:11] == 2'b10) begin
                  scc_bank[page8k[1:0]] <= cpu.wdata;
                  bank[page8k[1:0]] <= mapper_reg[0] ? (cpu.wdata & 8'h3F) : cpu.wdata;
               end
            end
            3'b001: begin
               // konami, bit 3 keeps page 4000 fixed.
               if (!(mapper_reg[3] && cpu.addr < 16'h6000) &&
                   (cpu.addr[15:11] == 5'b01010 || cpu.addr[15:13] >= 3'b011)) begin
                  bank[page8k[1:0]] <= mapper_reg[0] ? (cpu.wdata & 8'h1F) : cpu.wdata;
               end
            end
            3'b010, 3'b011: begin
               bank[page8k[1:0]] <= cpu.wdata;
            end
            3'b100, 3'b101: begin
               // ascii8 at 6000, 6800, 7000 and 7800.
               if (cpu.addr[15:13] == 3'b011)
                  bank[cpu.addr[12:11]] <= cpu.wdata;
            end
            default: begin
               // ascii16 writes both 8 kB halves of a page.
               if (cpu.addr[15:11] == 5'b01100) begin
                  bank[0] <= {cpu.wdata[6:0], 1'b0};
                  bank[1] <= {cpu.wdata[6:0], 1'b1};
               end
               if (cpu.addr[15:11] == 5'b01110) begin
                  bank[2] <= {cpu.wdata[6:0], 1'b0};
                  bank[3] <= {cpu.wdata[6:0], 1'b1};
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // flash address
   ////////////////////////////////////////

   // 64 kB mode pages in 16 kB steps from 0000.
   assign page16     = (mapper_reg[7:6] == 2'b01);
   assign page       = page16 ? {1'b0, cpu.addr[15:14]} : page8k;
   assign addr_valid = (page < 3'd4);

   always_comb begin
      // cfg bit 4 redirects the first two banks to the boot area.
      if (cfg_reg[4] && page[1:0] == 2'd0 && bank[0] == 8'd0)
         bank_value = 16'h03FA;
      else if (cfg_reg[4] && page[1:0] == 2'd1 && bank[1] == 8'd1)
         bank_value = 16'h03FB;
      else
         bank_value = {8'h00, bank[page[1:0]]} + {6'd0, offset_reg};
   end

   assign flash_off = page16 ? 23'({bank_value, cpu.addr[13:0]})
                             : 23'({bank_value, cpu.addr[12:0]});

   always_comb begin
      req.flash_addr = ROM_FLASH_BASE + flash_off;
      req.mem_addr   = base_ram + {4'd0, req.flash_addr};
      req.flash_rq   = cs & addr_valid;
      req.unmapped   = cs & (~addr_valid | scc_req);
   end

   ////////////////////////////////////////
   // scc decode
   ////////////////////////////////////////

   assign en_scc      = ~scc_mode[5] & (scc_bank[2][5:0] == 6'h3F) &
                        (cpu.addr[15:11] == 5'b10011);
   assign en_scc_plus = scc_mode[5] & scc_bank[3][7] & (cpu.addr[15:8] == 8'hB8);

   // segments switched to ram take the writes instead of the scc.
   assign ram_seg2 = (scc_mode[5] & scc_mode[2]) | scc_mode[4];
   assign ram_seg3 = scc_mode[4];

   assign scc_req  = cs & cpu.mreq &
                     ((cpu.rd & (en_scc | en_scc_plus)) |
                      (cpu.wr & ((en_scc & ~ram_seg2) | (en_scc_plus & ~ram_seg3))));
   assign scc_plus = cs & en_scc_plus;

   // a locked mapper register keeps its value.
   a_mapper_lock: assert property (@(posedge clk) disable iff (reset)
      mapper_reg[2] |=> $stable(mapper_reg));

endmodule

// File: hw/sd_mapper.sv
module sd_mapper import mfrsd_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        cs,
   input  cpu_bus_t    cpu,
   input  logic [26:0] base_ram,
   input  logic [7:0]  cfg_reg,
   input  logic [7:0]  rx_byte,
   output mem_req_t    req,
   output logic [7:0]  dout,
   output logic        tx_start,
   output logic        rx_start,
   output logic [7:0]  tx_byte,
   output logic        sd_cs_n
);

   logic [3:0][7:0] bank;
   logic [1:0]      page;
   logic            mem_valid;
   logic            card_en;
   logic            card_rd;
   logic            old_rd;
   logic            old_wr;
   logic            rd_rise;
   logic            wr_rise;
   logic            select_sd;

   // bank registers at 6000, 6800, 7000 and 7800.
   always_ff @(posedge clk) begin
      if (reset) begin
         bank <= {8'd3, 8'd2, 8'd1, 8'd0};
      end else if (cs & cpu.mreq & cpu.wr & (cpu.addr[15:13] == 3'b011)) begin
         bank[cpu.addr[12:11]] <= cpu.wdata;
      end
   end

   // 4000-bfff only, 8 kB per bank.
   assign page      = {cpu.addr[15], cpu.addr[13]};
   assign mem_valid = cpu.addr[15] ^ cpu.addr[14];

   always_comb begin
      req.flash_addr = SD_FLASH_BASE + {3'd0, bank[page][6:0], cpu.addr[12:0]};
      req.mem_addr   = base_ram + {4'd0, req.flash_addr};
      req.flash_rq   = cs & mem_valid & cfg_reg[0];
      req.unmapped   = cs & (~mem_valid | card_rd);
   end

   ////////////////////////////////////////
   // card window
   ////////////////////////////////////////

   assign card_en = cs & (bank[0][7:6] == 2'b01) & (cpu.addr[15:13] == 3'b010);
   assign card_rd = card_en & cpu.mreq & cpu.rd;
   assign dout    = (card_rd & ~cpu.addr[12]) ? rx_byte : 8'hFF;

   assign rd_rise = cpu.mreq & cpu.rd & ~old_rd;
   assign wr_rise = cpu.mreq & cpu.wr & ~old_wr;

   always_ff @(posedge clk) begin
      if (reset) begin
         old_rd    <= 1'b0;
         old_wr    <= 1'b0;
         select_sd <= 1'b1;
         tx_start  <= 1'b0;
         rx_start  <= 1'b0;
      end else begin
         old_rd   <= cpu.mreq & cpu.rd;
         old_wr   <= cpu.mreq & cpu.wr;
         tx_start <= wr_rise & card_en & ~cpu.addr[12] & ~select_sd;
         rx_start <= rd_rise & card_en & ~cpu.addr[12] & ~select_sd;
         // 5800-5fff holds the card select.
         if (wr_rise & card_en & (cpu.addr[12:11] == 2'b11))
            select_sd <= cpu.wdata[0];
      end
   end

   always_ff @(posedge clk) begin
      if (wr_rise)
         tx_byte <= cpu.wdata;
   end

   assign sd_cs_n = select_sd;

   a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(tx_start && rx_start));

endmodule

// File: hw/spi_ctrl.sv
module spi_ctrl (
   input  logic       clk,
   input  logic       reset,
   input  logic       tx_start,
   input  logic       rx_start,
   input  logic [7:0] tx_byte,
   input  logic       tick,
   input  logic       last_bit,
   output logic       run,
   output logic [7:0] rx_byte,
   output logic       sd_sclk,
   output logic       sd_mosi,
   input  logic       sd_miso
);

   typedef enum logic [1:0] {IDLE, LOW, HIGH} spi_state_t;

   spi_state_t state;
   logic [7:0] shreg;
   logic       miso_bit;

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         sd_sclk <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               // strobes only count here, busy ones are lost.
               if (tx_start | rx_start)
                  state <= LOW;
            end
            LOW: begin
               if (tick) begin
                  state   <= HIGH;
                  sd_sclk <= 1'b1;
               end
            end
            HIGH: begin
               if (tick) begin
                  state   <= last_bit ? IDLE : LOW;
                  sd_sclk <= 1'b0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // sample on the rising edge, shift on the falling edge.
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         if (tx_start)
            shreg <= tx_byte;
         else if (rx_start)
            shreg <= 8'hFF;
      end else if (tick && state == LOW) begin
         miso_bit <= sd_miso;
      end else if (tick) begin
         shreg <= {shreg[6:0], miso_bit};
         if (last_bit)
            rx_byte <= {shreg[6:0], miso_bit};
      end
   end

   assign run     = (state != IDLE);
   assign sd_mosi = (state == IDLE) | shreg[7];

   a_sclk_idle: assert property (@(posedge clk) disable iff (reset) state == IDLE |-> !sd_sclk);

endmodule

// File: hw/spi_bit_timer.sv
module spi_bit_timer import mfrsd_pkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic run,
   output logic tick,
   output logic last_bit
);

   logic [3:0] clk_cnt;
   logic [4:0] half_cnt;

   assign tick = run & (clk_cnt == SPI_HALF_CLKS - 4'd1);

   // half periods count from 0, the last one is the final high phase.
   assign last_bit = run & (half_cnt == {SPI_BITS, 1'b0} - 5'd1);

   always_ff @(posedge clk) begin
      if (reset || !run) begin
         clk_cnt  <= '0;
         half_cnt <= '0;
      end else if (tick) begin
         clk_cnt  <= '0;
         half_cnt <= half_cnt + 5'd1;
      end else begin
         clk_cnt <= clk_cnt + 4'd1;
      end
   end

endmodule

// File: hw/mfrsd_cart.sv
module mfrsd_cart import mfrsd_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  cpu_bus_t    cpu,
   input  logic        slot_cs,
   input  logic [26:0] base_ram,
   output mem_req_t    mem,
   output logic [7:0]  rd_data,
   output logic        rd_en,
   output logic        scc_req,
   output logic        scc_plus,
   output logic        sd_sclk,
   output logic        sd_mosi,
   output logic        sd_cs_n,
   input  logic        sd_miso
);

   logic       rom_cs;
   logic       sd_cs;
   mem_req_t   rom_req;
   mem_req_t   sd_req;
   logic [7:0] sd_dout;
   logic [7:0] cfg_reg;
   logic       tx_start;
   logic       rx_start;
   logic [7:0] tx_byte;
   logic [7:0] rx_byte;
   logic       run;
   logic       tick;
   logic       last_bit;

   // rom reads come from flash, so its internal data is idle.
   slot_expander slot_expander_inst (.rom_dout(8'hFF), .*);

   rom_mapper rom_mapper_inst (.cs(rom_cs), .req(rom_req), .*);

   sd_mapper sd_mapper_inst (.cs(sd_cs), .req(sd_req), .dout(sd_dout), .*);

   spi_ctrl spi_ctrl_inst (.*);

   spi_bit_timer spi_bit_timer_inst (.*);

endmodule

// File: bench/tb_mfrsd_cart.sv
module tb_mfrsd_cart import mfrsd_pkg::*; ();

   localparam logic [26:0] RAM_BASE = 27'h0400000;

   logic        clk;
   logic        reset;
   cpu_bus_t    cpu;
   logic        slot_cs;
   logic [26:0] base_ram;
   mem_req_t    mem;
   logic [7:0]  rd_data;
   logic        rd_en;
   logic        scc_req;
   logic        scc_plus;
   logic        sd_sclk;
   logic        sd_mosi;
   logic        sd_cs_n;
   logic        sd_miso;

   integer      seed = 32'h1204;
   integer      checks = 0;
   integer      errors = 0;
   integer      timeouts = 0;

   // outputs captured in the middle of a read cycle.
   mem_req_t    got_mem;
   logic [7:0]  got_data;
   logic        got_rd_en;
   logic        got_scc;
   logic        got_plus;

   mfrsd_cart mfrsd_cart_inst (.*);

   always #50 clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge clk);
      cpu = '{addr: addr, wdata: data, mreq: 1'b1, wr: 1'b1, rd: 1'b0};
      repeat (2) @(negedge clk);
      cpu = '{addr: addr, wdata: 8'h00, mreq: 1'b0, wr: 1'b0, rd: 1'b0};
   endtask

   task automatic cpu_read(input logic [15:0] addr);
      @(negedge clk);
      cpu = '{addr: addr, wdata: 8'h00, mreq: 1'b1, wr: 1'b0, rd: 1'b1};
      @(negedge clk);
      got_mem   = mem;
      got_data  = rd_data;
      got_rd_en = rd_en;
      got_scc   = scc_req;
      got_plus  = scc_plus;
      @(negedge clk);
      cpu = '{addr: addr, wdata: 8'h00, mreq: 1'b0, wr: 1'b0, rd: 1'b0};
   endtask

   // reads addr and expects a mapped flash access at flash.
   task automatic check_map(input logic [15:0] addr, input logic [22:0] flash);
      cpu_read(addr);
      check("mem.flash_addr", got_mem.flash_addr, flash);
      check("mem.mem_addr", got_mem.mem_addr, RAM_BASE + {4'd0, flash});
      check("mem.flash_rq", got_mem.flash_rq, 1'b1);
      check("mem.unmapped", got_mem.unmapped, 1'b0);
   endtask

   task automatic check_unmapped(input logic [15:0] addr);
      cpu_read(addr);
      check("mem.unmapped", got_mem.unmapped, 1'b1);
      check("mem.flash_rq", got_mem.flash_rq, 1'b0);
   endtask

   function automatic logic [22:0] rom_8k(input logic [15:0] bank, input logic [15:0] addr);
      return 23'h010000 + 23'(bank) * 23'h2000 + 23'(addr[12:0]);
   endfunction

   function automatic logic [22:0] sd_8k(input logic [7:0] bank, input logic [15:0] addr);
      return 23'h700000 + 23'(bank) * 23'h2000 + 23'(addr[12:0]);
   endfunction

   // waits at falling clock edges until sd_sclk reaches level.
   task automatic wait_sclk(input logic level, output logic ok);
      integer t;
      t = 0;
      while (sd_sclk !== level && t < 100) begin
         @(negedge clk);
         t = t + 1;
      end
      ok = (sd_sclk === level);
   endtask

   // sd card model, one byte out on miso while mosi is collected.
   task automatic card_exchange(input logic [7:0] card_byte, output logic [7:0] mosi_byte);
      integer i;
      logic   ok;
      mosi_byte = 8'h00;
      ok        = 1'b1;
      for (i = 0; i < 8 && ok; i = i + 1) begin
         sd_miso = card_byte[7 - i];
         wait_sclk(1'b1, ok);
         if (ok) begin
            mosi_byte = {mosi_byte[6:0], sd_mosi};
            wait_sclk(1'b0, ok);
         end
      end
      if (!ok) begin
         timeouts = timeouts + 1;
         $display("timeout: SCLK stopped toggling during the SPI transfer");
      end
      sd_miso = 1'b1;
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic test_subslot();
      apply_reset();
      cpu_write(SUBSLOT_REG_ADDR, 8'h94);
      cpu_read(SUBSLOT_REG_ADDR);
      check("rd_data", got_data, 8'h6B);
      check_unmapped(16'h0000);
      check_map(16'h4000, rom_8k(0, 16'h4000));
      check_unmapped(16'hC000);
      // page 1 to sd, page 2 stays on the rom mapper.
      cpu_write(SUBSLOT_REG_ADDR, 8'hDC);
      check_map(16'h4000, sd_8k(0, 16'h4000));
      check_map(16'h8000, rom_8k(2, 16'h8000));
   endtask

   task automatic test_konami_scc();
      apply_reset();
      cpu_write(SUBSLOT_REG_ADDR, 8'h54);
      cpu_write(16'h5000, 8'h12);
      cpu_write(16'h7000, 8'h25);
      cpu_write(16'h9000, 8'h3E);
      cpu_write(16'hB000, 8'h47);
      check_map(16'h4123, rom_8k(16'h12, 16'h4123));
      check_map(16'h6456, rom_8k(16'h25, 16'h6456));
      check_map(16'h8ABC, rom_8k(16'h3E, 16'h8ABC));
      check_map(16'hA777, rom_8k(16'h47, 16'hA777));
   endtask

   task automatic test_ascii16();
      apply_reset();
      cpu_write(SUBSLOT_REG_ADDR, 8'h54);
      cpu_write(OFFSET_LO_ADDR, 8'h05);
      cpu_write(OFFSET_HI_ADDR, 8'h00);
      cpu_write(MAPPER_REG_ADDR, 8'hC0);
      cpu_write(16'h6000, 8'h03);
      cpu_write(16'h7000, 8'h09);
      // 16 kB page n is 8 kB banks 2n and 2n+1, plus the offset.
      check_map(16'h4010, rom_8k(16'h03 * 2 + 5, 16'h4010));
      check_map(16'h6010, rom_8k(16'h03 * 2 + 1 + 5, 16'h6010));
      check_map(16'h8020, rom_8k(16'h09 * 2 + 5, 16'h8020));
      check_map(16'hA020, rom_8k(16'h09 * 2 + 1 + 5, 16'hA020));
      cpu_write(MAPPER_REG_ADDR, 8'hC4);
      cpu_write(MAPPER_REG_ADDR, 8'h00);
      // ascii16 stays active and 6000 sets both halves of page 4000.
      cpu_write(16'h6000, 8'h04);
      check_map(16'h4010, rom_8k(16'h04 * 2 + 5, 16'h4010));
      check_map(16'h6010, rom_8k(16'h04 * 2 + 1 + 5, 16'h6010));
   endtask

   task automatic test_scc();
      apply_reset();
      cpu_write(SUBSLOT_REG_ADDR, 8'h54);
      cpu_write(16'h9000, 8'h3F);
      cpu_read(16'h9800);
      check("scc_req", got_scc, 1'b1);
      check("scc_plus", got_plus, 1'b0);
      check("mem.unmapped", got_mem.unmapped, 1'b1);
      cpu_write(16'hBFFE, 8'h20);
      cpu_write(16'hB000, 8'h80);
      cpu_read(16'hB800);
      check("scc_req", got_scc, 1'b1);
      check("scc_plus", got_plus, 1'b1);
   endtask

   task automatic test_sd_paging();
      apply_reset();
      cpu_write(SUBSLOT_REG_ADDR, 8'hFC);
      cpu_write(16'h6000, 8'h05);
      cpu_write(16'h6800, 8'h0A);
      cpu_write(16'h7000, 8'h21);
      cpu_write(16'h7800, 8'h33);
      check_map(16'h4010, sd_8k(8'h05, 16'h4010));
      check_map(16'h6010, sd_8k(8'h0A, 16'h6010));
      check_map(16'h8010, sd_8k(8'h21, 16'h8010));
      check_map(16'hA010, sd_8k(8'h33, 16'hA010));
      check_unmapped(16'hC010);
      check_unmapped(16'h0010);
      // cfg register sits in the rom mapper.
      cpu_write(SUBSLOT_REG_ADDR, 8'h54);
      cpu_write(CFG_REG_ADDR, 8'h02);
      cpu_write(SUBSLOT_REG_ADDR, 8'hFC);
      cpu_read(16'h4010);
      check("mem.flash_rq", got_mem.flash_rq, 1'b0);
      check("mem.unmapped", got_mem.unmapped, 1'b0);
   endtask

   task automatic test_spi();
      logic [7:0] tx_value;
      logic [7:0] rx_value;
      logic [7:0] seen;
      tx_value = $random(seed);
      rx_value = $random(seed);
      apply_reset();
      cpu_write(SUBSLOT_REG_ADDR, 8'hFC);
      cpu_write(16'h6000, 8'h40);
      cpu_write(16'h5800, 8'h00);
      check("sd_cs_n", sd_cs_n, 1'b0);
      cpu_write(16'h4000, tx_value);
      card_exchange(8'hFF, seen);
      check("sd_mosi byte", seen, tx_value);
      cpu_read(16'h4000);
      card_exchange(rx_value, seen);
      check("sd_mosi byte", seen, 8'hFF);
      cpu_read(16'h4000);
      check("rd_data", got_data, rx_value);
      check("rd_en", got_rd_en, 1'b1);
   endtask

   initial begin
      clk      = 1'b0;
      reset    = 1'b1;
      cpu      = '0;
      slot_cs  = 1'b1;
      base_ram = RAM_BASE;
      sd_miso  = 1'b1;
      test_subslot();
      test_konami_scc();
      test_ascii16();
      test_scc();
      test_sd_paging();
      test_spi();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
hw/mfrsd_pkg.sv
hw/slot_expander.sv
hw/rom_mapper.sv
hw/sd_mapper.sv
hw/spi_ctrl.sv
hw/spi_bit_timer.sv
hw/mfrsd_cart.sv
bench/tb_mfrsd_cart.sv

// File: run_sim.sh
#!/bin/bash
# build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_mfrsd_cart \
   -f verilog.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Regression passed" sim.log; then
   exit 0
else
   echo "pass message not found in sim.log"
   exit 1
fi
